//--- exec_backend.f
+incdir+verilog
+incdir+test
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/bypass_if.sv
verilog/operand_bypass.sv
verilog/lane_alu.sv
verilog/mul_split.sv
verilog/mem_access.sv
verilog/stage_pipeline.sv
verilog/exec_backend.sv
test/exec_backend_tb.sv

//--- test/backend_model.svh
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

`include "exec_defines.svh"

localparam int NUM_REGS  = 1 << `REG_AW;
localparam int MEM_WORDS = 1 << `MEM_AW;

logic [`XLEN-1:0]    arch_rf [0:NUM_REGS-1];    // Written as DUT write-backs fire
logic [`XLEN-1:0]    spec_rf [0:NUM_REGS-1];    // Written in program order at issue
logic [`XLEN-1:0]    mem_model [0:MEM_WORDS-1];
logic [`CNT_W-1:0]   cnt_model;                 // Edges since reset release
pipe_pkg::rf_write_t exp_a_q [$];
pipe_pkg::rf_write_t exp_b_q [$];

function automatic void clear_model();
    for (int i = 0; i < NUM_REGS; i++) begin
        arch_rf[i] = i * 32'h0101_0101;         // r0 comes out as zero
        spec_rf[i] = arch_rf[i];
    end
    for (int i = 0; i < MEM_WORDS; i++)
        mem_model[i] = (i * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
    cnt_model = '0;
    exp_a_q.delete();
    exp_b_q.delete();
endfunction

function automatic logic [`XLEN-1:0] ref_alu(input isa_pkg::alu_op_e op,
                                             input logic [`XLEN-1:0] a,
                                             input logic [`XLEN-1:0] b);
    int sh;
    sh = b[4:0];
    case (op)
        isa_pkg::ALU_ADD:  return a + b;
        isa_pkg::ALU_SUB:  return a + ~b + 1;
        isa_pkg::ALU_AND:  return a & b;
        isa_pkg::ALU_OR:   return a | b;
        isa_pkg::ALU_XOR:  return a ^ b;
        isa_pkg::ALU_SLL:  return a << sh;
        isa_pkg::ALU_SRL:  return a >> sh;
        isa_pkg::ALU_SRA:  return (a >> sh) | ({`XLEN{a[`XLEN-1]}} & ~({`XLEN{1'b1}} >> sh));
        isa_pkg::ALU_SLT:  return (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b);
        isa_pkg::ALU_SLTU: return a < b;
        default:           return '0;
    endcase
endfunction

function automatic logic [`XLEN-1:0] lane_result(input isa_pkg::alu_op_e op,
                                                 input logic [`XLEN-1:0] v1,
                                                 input logic [`XLEN-1:0] v2,
                                                 input logic [`XLEN-1:0] imm,
                                                 input logic use_imm);
    if (op == isa_pkg::ALU_LUI)
        return imm;
    return ref_alu(op, v1, use_imm ? imm : v2);
endfunction

function automatic logic [`CNT_W-1:0] ref_mul(input logic [`XLEN-1:0] x,
                                              input logic [`XLEN-1:0] y,
                                              input logic sgn);
    if (sgn)
        return longint'($signed(x)) * longint'($signed(y));
    return {32'b0, x} * {32'b0, y};
endfunction

function automatic void commit_write(input pipe_pkg::rf_write_t w);
    if (w.we && w.addr != '0)
        arch_rf[w.addr] = w.data;
endfunction

`endif

//--- test/exec_backend_tb.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_backend_tb;

    localparam int ISSUE_TIMEOUT = 20;

    logic               clk;
    logic               rst;
    isa_pkg::alu_op_e   a_op, b_op;
    logic [`XLEN-1:0]   a_src1, a_src2, a_imm, b_src1, b_src2, b_imm;
    logic [`REG_AW-1:0] a_raddr1, a_raddr2, a_waddr, b_raddr1, b_raddr2, b_waddr;
    logic               a_use_imm, a_rf_we, b_use_imm, b_rf_we;
    isa_pkg::wb_sel_e   b_wb_sel;
    logic               b_mul_signed, b_mem_re, b_mem_we;
    logic               mem_rvalid, mem_wvalid, mem_ready;
    logic [`XLEN-1:0]   mem_addr, mem_wdata, mem_rdata;
    logic               stall, wb_we_a, wb_we_b;
    logic [`REG_AW-1:0] wb_waddr_a, wb_waddr_b;
    logic [`XLEN-1:0]   wb_wdata_a, wb_wdata_b;

    // Next pair to issue, index 0 is lane A and 1 is lane B
    isa_pkg::alu_op_e   in_op  [2];
    logic [`REG_AW-1:0] in_r1  [2];
    logic [`REG_AW-1:0] in_r2  [2];
    logic [`REG_AW-1:0] in_wa  [2];
    logic [`XLEN-1:0]   in_imm [2];
    logic               in_ui  [2];
    logic               in_we  [2];
    isa_pkg::wb_sel_e   in_sel;
    logic               in_sgn, in_re, in_st;

    logic               m_pend;     // Memory op sitting in MEM
    int                 m_wait;     // Ready-low cycles still to go
    logic [`XLEN-1:0]   m_rdata;
    logic               adv_prev;   // Last edge moved the pipe
    logic               timed_out;
    int                 errors, checks, tests;

    `include "backend_model.svh"

    exec_backend uut (
        .clk(clk), .rst(rst),
        .a_op(a_op), .a_src1(a_src1), .a_src2(a_src2), .a_raddr1(a_raddr1),
        .a_raddr2(a_raddr2), .a_imm(a_imm), .a_use_imm(a_use_imm), .a_rf_we(a_rf_we),
        .a_waddr(a_waddr),
        .b_op(b_op), .b_src1(b_src1), .b_src2(b_src2), .b_raddr1(b_raddr1),
        .b_raddr2(b_raddr2), .b_imm(b_imm), .b_use_imm(b_use_imm), .b_rf_we(b_rf_we),
        .b_waddr(b_waddr), .b_wb_sel(b_wb_sel), .b_mul_signed(b_mul_signed),
        .b_mem_re(b_mem_re), .b_mem_we(b_mem_we),
        .mem_rvalid(mem_rvalid), .mem_wvalid(mem_wvalid), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .stall(stall), .wb_we_a(wb_we_a), .wb_waddr_a(wb_waddr_a), .wb_wdata_a(wb_wdata_a),
        .wb_we_b(wb_we_b), .wb_waddr_b(wb_waddr_b), .wb_wdata_b(wb_wdata_b)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_wb(input string lane, input pipe_pkg::rf_write_t got,
                            input pipe_pkg::rf_write_t exp);
        checks++;
        if (got.we !== exp.we || (exp.we && (got.addr !== exp.addr || got.data !== exp.data))) begin
            errors++;
            $display("MISMATCH %0t: lane %s write-back we=%0b r%0d=%h, expected we=%0b r%0d=%h",
                     $time, lane, got.we, got.addr, got.data, exp.we, exp.addr, exp.data);
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %0t: stall is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_mem_req(input logic got_re, input logic got_we,
                                 input logic [`XLEN-1:0] got_addr,
                                 input logic [`XLEN-1:0] got_wdata,
                                 input logic exp_re, input logic exp_we,
                                 input logic [`XLEN-1:0] exp_addr,
                                 input logic [`XLEN-1:0] exp_wdata);
        checks++;
        if (got_re !== exp_re || got_we !== exp_we ||
            ((exp_re || exp_we) && got_addr !== exp_addr) ||
            (exp_we && got_wdata !== exp_wdata)) begin
            errors++;
            $display("MISMATCH %0t: memory request re=%b we=%b addr=%h data=%h, expected %b %b %h %h",
                     $time, got_re, got_we, got_addr, got_wdata,
                     exp_re, exp_we, exp_addr, exp_wdata);
        end
    endtask

    task automatic set_bubble();
        for (int l = 0; l < 2; l++) begin
            in_op[l]  = isa_pkg::ALU_ADD;
            in_r1[l]  = '0;
            in_r2[l]  = '0;
            in_wa[l]  = '0;
            in_imm[l] = '0;
            in_ui[l]  = 1'b0;
            in_we[l]  = 1'b0;
        end
        in_sel = isa_pkg::WB_ALU;
        in_sgn = 1'b0;
        in_re  = 1'b0;
        in_st  = 1'b0;
    endtask

    task automatic rand_alu_lane(input int lane, input int top);
        in_op[lane]  = isa_pkg::alu_op_e'($urandom_range(0, 10));
        in_r1[lane]  = $urandom_range(0, top);
        in_r2[lane]  = $urandom_range(0, top);
        in_wa[lane]  = $urandom_range(0, top);
        in_imm[lane] = $urandom();
        in_ui[lane]  = $urandom_range(0, 1);
        in_we[lane]  = ($urandom_range(0, 7) != 0);
    endtask

    // Lane B word access at r0 plus a small offset
    task automatic set_mem_op(input logic is_load);
        in_op[1]  = isa_pkg::ALU_ADD;
        in_ui[1]  = 1'b1;
        in_r1[1]  = '0;
        in_imm[1] = $urandom_range(0, 15) * 4;
        in_re     = is_load;
        in_st     = !is_load;
        in_we[1]  = is_load;
        in_sel    = is_load ? isa_pkg::WB_LOAD : isa_pkg::WB_ALU;
    endtask

    task automatic build_pair(input int kind);
        int pick;
        set_bubble();
        pick = $urandom_range(0, 3);
        if (kind != 0) begin
            rand_alu_lane(0, (kind == 1) ? 31 : (kind == 2) ? 3 : 7);
            rand_alu_lane(1, (kind == 1) ? 31 : (kind == 2) ? 3 : 7);
        end
        if (kind == 3) begin
            in_sel   = pick[0] ? isa_pkg::WB_MUL_HI : isa_pkg::WB_MUL_LO;
            in_sgn   = pick[1];
            in_we[1] = 1'b1;
        end else if (kind == 4 && pick < 3) begin
            set_mem_op(pick == 0);
        end else if (kind == 5) begin
            if (pick == 0)
                set_mem_op(1'b1);
            else if (pick == 1)
                in_sel = isa_pkg::WB_CNT_LO;
            else if (pick == 2)
                in_sel = isa_pkg::WB_CNT_HI;
        end
        // Issue rules: lane B neither reads nor writes lane A's destination
        if (in_we[0]) begin
            if (in_r1[1] == in_wa[0])
                in_r1[1] = '0;
            if (in_r2[1] == in_wa[0])
                in_r2[1] = '0;
            if (in_we[1] && in_wa[1] == in_wa[0])
                in_wa[1] = in_wa[0] ^ 1'b1;
        end
    endtask

    task automatic drive_inputs(input logic fresh);
        a_op         = in_op[0];
        a_raddr1     = in_r1[0];
        a_raddr2     = in_r2[0];
        a_imm        = in_imm[0];
        a_use_imm    = in_ui[0];
        a_rf_we      = in_we[0];
        a_waddr      = in_wa[0];
        b_op         = in_op[1];
        b_raddr1     = in_r1[1];
        b_raddr2     = in_r2[1];
        b_imm        = in_imm[1];
        b_use_imm    = in_ui[1];
        b_rf_we      = in_we[1];
        b_waddr      = in_wa[1];
        b_wb_sel     = in_sel;
        b_mul_signed = in_sgn;
        b_mem_re     = in_re;
        b_mem_we     = in_st;
        if (fresh) begin                                // Held while stalled
            a_src1 = arch_rf[in_r1[0]];
            a_src2 = arch_rf[in_r2[0]];
            b_src1 = arch_rf[in_r1[1]];
            b_src2 = arch_rf[in_r2[1]];
        end
        if (m_pend && m_wait == 0) begin
            mem_ready = 1'b1;
            mem_rdata = m_rdata;
        end else begin
            if (m_pend)
                m_wait--;
            mem_ready = 1'b0;
            mem_rdata = $urandom();                     // Junk until ready
        end
    endtask

    task automatic predict_pair();
        logic [`XLEN-1:0]  a1, a2, b1, b2, a_res, b_res, b_val;
        logic [`CNT_W-1:0] prod;
        int                idx;
        a1 = spec_rf[in_r1[0]];
        a2 = spec_rf[in_r2[0]];
        b1 = spec_rf[in_r1[1]];
        b2 = spec_rf[in_r2[1]];
        a_res = lane_result(in_op[0], a1, a2, in_imm[0], in_ui[0]);
        b_res = lane_result(in_op[1], b1, b2, in_imm[1], in_ui[1]);
        prod  = ref_mul(b1, b2, in_sgn);
        idx   = b_res[`MEM_AW-1:0];
        // Request taken at the coming edge
        check_mem_req(mem_rvalid, mem_wvalid, mem_addr, mem_wdata, in_re, in_st, b_res, b2);
        m_pend = in_re || in_st;
        m_wait = $urandom_range(0, 3);
        if (in_st)
            mem_model[idx] = b2;
        m_rdata = mem_model[idx];
        case (in_sel)
            isa_pkg::WB_LOAD:   b_val = mem_model[idx];
            isa_pkg::WB_MUL_LO: b_val = prod[31:0];
            isa_pkg::WB_MUL_HI: b_val = prod[63:32];
            isa_pkg::WB_CNT_LO: b_val = cnt_model[31:0];
            isa_pkg::WB_CNT_HI: b_val = cnt_model[63:32];
            default:            b_val = b_res;
        endcase
        exp_a_q.push_back({in_we[0], in_wa[0], a_res});
        exp_b_q.push_back({in_we[1], in_wa[1], b_val});
        if (in_we[0] && in_wa[0] != '0)
            spec_rf[in_wa[0]] = a_res;
        if (in_we[1] && in_wa[1] != '0)
            spec_rf[in_wa[1]] = b_val;
    endtask

    task automatic sample_cycle(output logic taken);
        pipe_pkg::rf_write_t ea, eb;
        logic                exp_stall;
        exp_stall = m_pend && !mem_ready;
        check_stall(stall, exp_stall);
        if (adv_prev) begin                             // WB holds a new pair
            ea = '0;
            eb = '0;
            if (exp_a_q.size() >= 2) begin
                ea = exp_a_q.pop_front();
                eb = exp_b_q.pop_front();
                commit_write(ea);
                commit_write(eb);
            end
            check_wb("A", {wb_we_a, wb_waddr_a, wb_wdata_a}, ea);
            check_wb("B", {wb_we_b, wb_waddr_b, wb_wdata_b}, eb);
        end
        taken    = !exp_stall;
        adv_prev = taken;
        if (taken)
            predict_pair();
    endtask

    task automatic issue_pair();
        logic taken;
        int   waited;
        taken  = 1'b0;
        waited = 0;
        while (!taken && !timed_out) begin
            @(posedge clk);
            cnt_model = cnt_model + 1'b1;
            #1;
            drive_inputs(waited == 0);
            @(negedge clk);
            sample_cycle(taken);
            waited++;
            if (!taken && waited >= ISSUE_TIMEOUT) begin
                $display("Timeout: pair still held by stall after %0d cycles", waited);
                timed_out = 1'b1;
                errors++;
            end
        end
    endtask

    task automatic run_test(input int kind, input string name, input int count);
        int err0;
        err0 = errors;
        for (int i = 0; i < count && !timed_out; i++) begin
            build_pair(kind);
            issue_pair();
        end
        set_bubble();
        repeat (2) issue_pair();                        // Flush the last pair to WB
        tests++;
        $display("Test %0d (%s) finished with %0d errors", tests, name, errors - err0);
    endtask

    initial begin
        void'($urandom(75));
        errors    = 0;
        checks    = 0;
        tests     = 0;
        timed_out = 1'b0;
        adv_prev  = 1'b1;
        m_pend    = 1'b0;
        m_wait    = 0;
        m_rdata   = '0;
        clear_model();
        set_bubble();
        rst = 1'b1;
        drive_inputs(1'b1);
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        run_test(0, "idle after reset", 6);
        run_test(1, "independent ALU pairs", 200);
        run_test(2, "dependent chains", 200);
        run_test(3, "multiply", 100);
        run_test(4, "loads and stores", 200);
        run_test(5, "counter reads", 60);
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- verilog/bypass_if.sv
`timescale 1ns/1ps

// Register writes in flight in MEM and WB, seen by the forwarding logic
interface bypass_if;

    pipe_pkg::rf_write_t mem_a;
    pipe_pkg::rf_write_t mem_b;     // Final lane B value after the write-back select
    pipe_pkg::rf_write_t wb_a;
    pipe_pkg::rf_write_t wb_b;

    modport src (
        output mem_a,
        output mem_b,
        output wb_a,
        output wb_b
    );

    modport snk (
        input mem_a,
        input mem_b,
        input wb_a,
        input wb_b
    );

endinterface

//--- verilog/exec_backend.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_backend (
    input  logic                clk,
    input  logic                rst,
    // Lane A
    input  isa_pkg::alu_op_e    a_op,
    input  logic [`XLEN-1:0]    a_src1,
    input  logic [`XLEN-1:0]    a_src2,
    input  logic [`REG_AW-1:0]  a_raddr1,
    input  logic [`REG_AW-1:0]  a_raddr2,
    input  logic [`XLEN-1:0]    a_imm,
    input  logic                a_use_imm,
    input  logic                a_rf_we,
    input  logic [`REG_AW-1:0]  a_waddr,
    // Lane B
    input  isa_pkg::alu_op_e    b_op,
    input  logic [`XLEN-1:0]    b_src1,
    input  logic [`XLEN-1:0]    b_src2,
    input  logic [`REG_AW-1:0]  b_raddr1,
    input  logic [`REG_AW-1:0]  b_raddr2,
    input  logic [`XLEN-1:0]    b_imm,
    input  logic                b_use_imm,
    input  logic                b_rf_we,
    input  logic [`REG_AW-1:0]  b_waddr,
    input  isa_pkg::wb_sel_e    b_wb_sel,
    input  logic                b_mul_signed,
    input  logic                b_mem_re,
    input  logic                b_mem_we,
    // Data memory
    output logic                mem_rvalid,
    output logic                mem_wvalid,
    output logic [`XLEN-1:0]    mem_addr,
    output logic [`XLEN-1:0]    mem_wdata,
    input  logic                mem_ready,
    input  logic [`XLEN-1:0]    mem_rdata,
    // Write-back
    output logic                stall,
    output logic                wb_we_a,
    output logic [`REG_AW-1:0]  wb_waddr_a,
    output logic [`XLEN-1:0]    wb_wdata_a,
    output logic                wb_we_b,
    output logic [`REG_AW-1:0]  wb_waddr_b,
    output logic [`XLEN-1:0]    wb_wdata_b
);

    logic [`XLEN-1:0]    a_opnd1, a_opnd2, b_opnd1, b_opnd2;
    logic [`XLEN-1:0]    a_alu_res, b_alu_res;
    logic [`CNT_W-1:0]   product;
    pipe_pkg::lane_ex_t  a_ex, b_ex;
    pipe_pkg::rf_write_t wb_a, wb_b;

    bypass_if byp_bus ();

    operand_bypass u_bypass (
        .a_src1(a_src1), .a_src2(a_src2), .b_src1(b_src1), .b_src2(b_src2),
        .a_raddr1(a_raddr1), .a_raddr2(a_raddr2), .b_raddr1(b_raddr1), .b_raddr2(b_raddr2),
        .bus(byp_bus.snk),
        .a_opnd1(a_opnd1), .a_opnd2(a_opnd2), .b_opnd1(b_opnd1), .b_opnd2(b_opnd2)
    );

    lane_alu u_alu_a (.op(a_op), .opnd1(a_opnd1), .opnd2(a_opnd2), .imm(a_imm),
                      .use_imm(a_use_imm), .result(a_alu_res));
    lane_alu u_alu_b (.op(b_op), .opnd1(b_opnd1), .opnd2(b_opnd2), .imm(b_imm),
                      .use_imm(b_use_imm), .result(b_alu_res));

    mul_split u_mul (.clk(clk), .rst(rst), .stall(stall), .x(b_opnd1), .y(b_opnd2),
                     .is_signed(b_mul_signed), .product(product));

    mem_access u_mem (.clk(clk), .rst(rst), .mem_re(b_mem_re), .mem_we(b_mem_we),
                      .mem_ready(mem_ready), .mem_rvalid(mem_rvalid),
                      .mem_wvalid(mem_wvalid), .stall(stall));

    assign mem_addr  = b_alu_res;   // Address from the lane B adder
    assign mem_wdata = b_opnd2;

    assign a_ex = '{wr: '{we: a_rf_we, addr: a_waddr, data: a_alu_res}, wb_sel: isa_pkg::WB_ALU};
    assign b_ex = '{wr: '{we: b_rf_we, addr: b_waddr, data: b_alu_res}, wb_sel: b_wb_sel};

    stage_pipeline u_pipe (.clk(clk), .rst(rst), .stall(stall), .a_ex(a_ex), .b_ex(b_ex),
                           .product(product), .mem_rdata(mem_rdata), .bus(byp_bus.src),
                           .wb_a(wb_a), .wb_b(wb_b));

    assign wb_we_a    = wb_a.we;
    assign wb_waddr_a = wb_a.addr;
    assign wb_wdata_a = wb_a.data;
    assign wb_we_b    = wb_b.we;
    assign wb_waddr_b = wb_b.addr;
    assign wb_wdata_b = wb_b.data;

endmodule

//--- verilog/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Datapath and address width
`define XLEN 32

// Register file address width
`define REG_AW 5

// Free-running cycle counter width
`define CNT_W 64

// Data-memory address bits decoded by the memory model
`define MEM_AW 10

`endif

//--- verilog/isa_pkg.sv
package isa_pkg;

    // ALU operation, one per lane
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI                 // Passes the immediate
    } alu_op_e;

    // Lane B write-back source, chosen in MEM
    typedef enum logic [2:0] {
        WB_ALU,
        WB_LOAD,
        WB_MUL_LO,
        WB_MUL_HI,
        WB_CNT_LO,
        WB_CNT_HI
    } wb_sel_e;

    // Memory operation held in MEM
    typedef enum logic [1:0] {MEM_IDLE, MEM_LOAD, MEM_STORE} mem_op_e;

endpackage

//--- verilog/lane_alu.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module lane_alu (
    input  isa_pkg::alu_op_e op,
    input  logic [`XLEN-1:0] opnd1,
    input  logic [`XLEN-1:0] opnd2,
    input  logic [`XLEN-1:0] imm,
    input  logic             use_imm,
    output logic [`XLEN-1:0] result
);

    logic [`XLEN-1:0] src2;
    logic [4:0]       shamt;

    assign src2  = use_imm ? imm : opnd2;   // Immediate form
    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            isa_pkg::ALU_ADD:  result = opnd1 + src2;
            isa_pkg::ALU_SUB:  result = opnd1 - src2;
            isa_pkg::ALU_AND:  result = opnd1 & src2;
            isa_pkg::ALU_OR:   result = opnd1 | src2;
            isa_pkg::ALU_XOR:  result = opnd1 ^ src2;
            isa_pkg::ALU_SLL:  result = opnd1 << shamt;
            isa_pkg::ALU_SRL:  result = opnd1 >> shamt;
            isa_pkg::ALU_SRA:  result = $unsigned($signed(opnd1) >>> shamt);
            isa_pkg::ALU_SLT: begin
                result = {{(`XLEN-1){1'b0}}, $signed(opnd1) < $signed(src2)};
            end
            isa_pkg::ALU_SLTU: begin
                result = {{(`XLEN-1){1'b0}}, opnd1 < src2};
            end
            isa_pkg::ALU_LUI:  result = imm;      // Upper immediate already placed
            default:           result = '0;
        endcase
    end

endmodule

//--- verilog/mem_access.sv
`timescale 1ns/1ps

module mem_access (
    input  logic clk,
    input  logic rst,
    input  logic mem_re,
    input  logic mem_we,
    input  logic mem_ready,
    output logic mem_rvalid,
    output logic mem_wvalid,
    output logic stall
);

    isa_pkg::mem_op_e pend_op;  // Operation sitting in MEM

    // Requests are level strobes straight from the lane B EX inputs
    assign mem_rvalid = mem_re;
    assign mem_wvalid = mem_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_op <= isa_pkg::MEM_IDLE;
        end else if (!stall) begin                  // Advancing edge
            if (mem_re)
                pend_op <= isa_pkg::MEM_LOAD;
            else if (mem_we)
                pend_op <= isa_pkg::MEM_STORE;
            else
                pend_op <= isa_pkg::MEM_IDLE;
        end
    end

    // Hold the whole pipe until memory answers
    assign stall = (pend_op != isa_pkg::MEM_IDLE) && !mem_ready;

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(mem_rvalid && mem_wvalid))
        else $error("load and store strobes high together");

    // A stall can only start right after a request was taken
    a_stall_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(stall) |-> $past(mem_rvalid || mem_wvalid))
        else $error("stall raised without a pending memory operation");

endmodule

//--- verilog/mul_split.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module mul_split (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic [`XLEN-1:0]  x,
    input  logic [`XLEN-1:0]  y,
    input  logic              is_signed,
    output logic [`CNT_W-1:0] product
);

    logic [`CNT_W-1:0]   x_ext;
    logic [`CNT_W-1:0]   y_ext;
    logic [`CNT_W-1:0]   x_hi;
    logic [`CNT_W-1:0]   x_lo;
    pipe_pkg::mul_part_t part_d;
    pipe_pkg::mul_part_t part_q;

    // Operands widened to the full product width
    assign x_ext = is_signed ? {{(`CNT_W-`XLEN){x[`XLEN-1]}}, x} : {{(`CNT_W-`XLEN){1'b0}}, x};
    assign y_ext = is_signed ? {{(`CNT_W-`XLEN){y[`XLEN-1]}}, y} : {{(`CNT_W-`XLEN){1'b0}}, y};

    // x split at bit 16, upper half keeps the sign
    assign x_hi = {{16{x_ext[`CNT_W-1]}}, x_ext[`CNT_W-1:16]};
    assign x_lo = {{(`CNT_W-16){1'b0}}, x_ext[15:0]};

    // Modulo 2^64 arithmetic gives the exact product either way
    assign part_d.hi_part = (x_hi * y_ext) << 16;
    assign part_d.lo_part = x_lo * y_ext;

    always_ff @(posedge clk) begin
        if (rst) begin
            part_q <= '0;
        end else if (!stall) begin
            part_q <= part_d;
        end
    end

    // MEM stage final sum
    assign product = part_q.hi_part + part_q.lo_part;

    // The multiply in MEM must see the same partials until the pipe moves
    a_part_hold: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(part_q))
        else $error("mul_split partials changed across a stalled edge");

endmodule

//--- verilog/operand_bypass.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module operand_bypass (
    input  logic [`XLEN-1:0]   a_src1,
    input  logic [`XLEN-1:0]   a_src2,
    input  logic [`XLEN-1:0]   b_src1,
    input  logic [`XLEN-1:0]   b_src2,
    input  logic [`REG_AW-1:0] a_raddr1,
    input  logic [`REG_AW-1:0] a_raddr2,
    input  logic [`REG_AW-1:0] b_raddr1,
    input  logic [`REG_AW-1:0] b_raddr2,
    bypass_if.snk              bus,
    output logic [`XLEN-1:0]   a_opnd1,
    output logic [`XLEN-1:0]   a_opnd2,
    output logic [`XLEN-1:0]   b_opnd1,
    output logic [`XLEN-1:0]   b_opnd2
);

    // Youngest matching write wins, lane B is younger within a pair
    function automatic logic [`XLEN-1:0] pick(
        input logic [`XLEN-1:0]   raw,
        input logic [`REG_AW-1:0] addr,
        input pipe_pkg::rf_write_t m_b,
        input pipe_pkg::rf_write_t m_a,
        input pipe_pkg::rf_write_t w_b,
        input pipe_pkg::rf_write_t w_a
    );
        logic [`XLEN-1:0] val;
        val = raw;
        if (addr != '0) begin                               // r0 is hardwired
            if (m_b.we && m_b.addr == addr)
                val = m_b.data;
            else if (m_a.we && m_a.addr == addr)
                val = m_a.data;
            else if (w_b.we && w_b.addr == addr)
                val = w_b.data;
            else if (w_a.we && w_a.addr == addr)
                val = w_a.data;
        end
        return val;
    endfunction

    assign a_opnd1 = pick(a_src1, a_raddr1, bus.mem_b, bus.mem_a, bus.wb_b, bus.wb_a);
    assign a_opnd2 = pick(a_src2, a_raddr2, bus.mem_b, bus.mem_a, bus.wb_b, bus.wb_a);
    assign b_opnd1 = pick(b_src1, b_raddr1, bus.mem_b, bus.mem_a, bus.wb_b, bus.wb_a);
    assign b_opnd2 = pick(b_src2, b_raddr2, bus.mem_b, bus.mem_a, bus.wb_b, bus.wb_a);

endmodule

//--- verilog/pipe_pkg.sv
`include "exec_defines.svh"

package pipe_pkg;

    // One register file write
    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] addr;
        logic [`XLEN-1:0]   data;
    } rf_write_t;

    // EX-to-MEM payload of one lane
    typedef struct packed {
        rf_write_t         wr;      // Data holds the ALU result
        isa_pkg::wb_sel_e  wb_sel;  // Lane A is always alu
    } lane_ex_t;

    // Multiplier partial sums between EX and MEM
    typedef struct packed {
        logic [`CNT_W-1:0] hi_part;
        logic [`CNT_W-1:0] lo_part;
    } mul_part_t;

endpackage

//--- verilog/stage_pipeline.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module stage_pipeline (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  pipe_pkg::lane_ex_t  a_ex,
    input  pipe_pkg::lane_ex_t  b_ex,
    input  logic [`CNT_W-1:0]   product,
    input  logic [`XLEN-1:0]    mem_rdata,
    bypass_if.src               bus,
    output pipe_pkg::rf_write_t wb_a,
    output pipe_pkg::rf_write_t wb_b
);

    pipe_pkg::lane_ex_t  mem_a_q;
    pipe_pkg::lane_ex_t  mem_b_q;
    logic [`CNT_W-1:0]   cnt;
    logic [`CNT_W-1:0]   mem_cnt_q;  // Counter value as the instruction left EX
    logic [`XLEN-1:0]    mem_b_data;
    pipe_pkg::rf_write_t mem_b_wr;
    pipe_pkg::rf_write_t wb_a_q;
    pipe_pkg::rf_write_t wb_b_q;

    // Free-running, keeps counting through stalls
    always_ff @(posedge clk) begin
        if (rst)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // EX/MEM
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_a_q.wr.we  <= 1'b0;
            mem_b_q.wr.we  <= 1'b0;
            mem_b_q.wb_sel <= isa_pkg::WB_ALU;
        end else if (!stall) begin
            mem_a_q   <= a_ex;
            mem_b_q   <= b_ex;
            mem_cnt_q <= cnt;
        end
    end

    // Lane B write-back source
    always_comb begin
        case (mem_b_q.wb_sel)
            isa_pkg::WB_ALU:    mem_b_data = mem_b_q.wr.data;
            isa_pkg::WB_LOAD:   mem_b_data = mem_rdata;     // Valid once mem_ready is high
            isa_pkg::WB_MUL_LO: mem_b_data = product[`XLEN-1:0];
            isa_pkg::WB_MUL_HI: mem_b_data = product[`CNT_W-1:`XLEN];
            isa_pkg::WB_CNT_LO: mem_b_data = mem_cnt_q[`XLEN-1:0];
            isa_pkg::WB_CNT_HI: mem_b_data = mem_cnt_q[`CNT_W-1:`XLEN];
            default:            mem_b_data = mem_b_q.wr.data;
        endcase
    end

    assign mem_b_wr = '{we: mem_b_q.wr.we, addr: mem_b_q.wr.addr, data: mem_b_data};

    // MEM/WB
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_a_q.we <= 1'b0;
            wb_b_q.we <= 1'b0;
        end else if (!stall) begin
            wb_a_q <= mem_a_q.wr;
            wb_b_q <= mem_b_wr;
        end
    end

    assign bus.mem_a = mem_a_q.wr;
    assign bus.mem_b = mem_b_wr;
    assign bus.wb_a  = wb_a_q;
    assign bus.wb_b  = wb_b_q;

    assign wb_a = wb_a_q;
    assign wb_b = wb_b_q;

    // A waiting load must not leak stale read data into WB
    a_load_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_b_q.wb_sel == isa_pkg::WB_LOAD && stall) |=> $stable(wb_b_q))
        else $error("MEM/WB changed while a load waited for memory");

endmodule
